// ==== files.f ====
+incdir+.
mcCtlPkg.sv
mcCasArbiter.sv
mcCmdEncoder.sv
mcCtl.sv
tbClkGen.sv
mcCtl_props.sv
tbMcCtl.sv

// ==== mcCasArbiter.sv ====
// ------------------------------
// Decides each cycle whether the pending CAS issues and in which slot pair
// Grant is combinational, history registers update on the clock edge
// ------------------------------

`include "mcCtl_macros.svh"

module mcCasArbiter #(
   // 1 keeps rank switches out of slot 2 for the long gap at fast clocks
   parameter bit longRankSwitch = 1'b0
) (
   input  logic              clk,
   input  logic              rst,
   input  mcCtlPkg::casReq_t casReq,
   input  logic              perCasBlock,
   output logic              tranSentC,
   output logic              casSlot2,
   output logic              prevCmdAP
);

   // ------------------------------
   // CAS history
   // ------------------------------

   // CAS sent last cycle and the cycle before
   logic                  prevCas;
   logic                  prev2Cas;
   // Rank of the last read or write request
   logic [`MC_RKBITS-1:0] prevRank;
   // Last sent CAS went in slots 4-5
   logic                  prevSlot2;

   // Read gated by the periodic read window
   logic readAllowed;
   // Exactly one eligible CAS is present
   logic casEligible;
   // Any CAS present, blocked or not
   logic casAny;
   logic casSent;
   logic rankDiff;

   assign readAllowed = casReq.read & ~perCasBlock;
   assign casEligible = readAllowed ^ casReq.write;
   assign casAny      = casReq.read | casReq.write;
   assign casSent     = casAny & tranSentC;
   assign rankDiff    = casReq.rank != prevRank;

   // ------------------------------
   // Grant and slot choice
   // ------------------------------

   always_comb begin
      casSlot2  = 1'b0;
      tranSentC = 1'b0;
      if (!casEligible) begin
         // Nothing to place, only a blocked read holds the grant low
         tranSentC = ~(casReq.read & perCasBlock);
      end else if (!prevCas) begin
         // Bus idle last cycle
         // Stay in slot 2 behind a slot-2 CAS two cycles back
         tranSentC = 1'b1;
         casSlot2  = longRankSwitch & prev2Cas & prevSlot2;
      end else if (!rankDiff) begin
         // Same rank keeps the previous slot pair, tCCD is met
         tranSentC = 1'b1;
         casSlot2  = prevSlot2;
      end else if (!prevSlot2) begin
         // Rank switch after slot 0
         // Reads move to slot 2, writes need a full dead cycle
         tranSentC = casReq.read & ~longRankSwitch;
         casSlot2  = casReq.read & ~longRankSwitch;
      end else begin
         // Rank switch right after slot 2 has no room this cycle
         tranSentC = 1'b0;
      end
   end

   // ------------------------------
   // History registers
   // ------------------------------

   always_ff @(posedge clk) begin
      if (!rst) begin
         prevCas   <= 1'b0;
         prev2Cas  <= 1'b0;
         prevRank  <= '0;
         prevSlot2 <= 1'b0;
         prevCmdAP <= 1'b0;
      end else begin
         prevCas  <= casSent;
         prev2Cas <= prevCas;
         // Rank tracks the request even when it is refused
         if (casAny) begin
            prevRank <= casReq.rank;
         end
         if (casSent) begin
            prevSlot2 <= casSlot2;
            prevCmdAP <= casReq.autoPre;
         end
      end
   end

endmodule

// ==== mcCmdEncoder.sv ====
// ------------------------------
// Places CAS, activate, precharge and maintenance commands into the eight slots
// Purely combinational, fed by the scheduler and the CAS arbiter grant
// ------------------------------

`include "mcCtl_macros.svh"

module mcCmdEncoder (
   input  mcCtlPkg::casReq_t   casReq,
   input  mcCtlPkg::actReq_t   actReq,
   input  mcCtlPkg::preReq_t   preReq,
   input  mcCtlPkg::maintReq_t maintReq,
   input  logic                tranSentC,
   input  logic                casSlot2,
   output mcCtlPkg::cmdBus_t   cmd
);

   import mcCtlPkg::*;

   // Idle slot level of address, bank and group
   localparam slotVec_t idleAddr = (`MC_NOP_ADDR_LOW != 0) ? '0 : '1;

   // Fixed slot pairs
   localparam logic [2:0] actBase = 3'd2;
   localparam logic [2:0] preBase = 3'd6;

   // ------------------------------
   // Slot pair helpers
   // ------------------------------

   // Opcode on RAS/CAS/WE and on A16..A14
   function automatic cmdBus_t putOp(cmdBus_t c, logic [2:0] base, ddrOp_t op);
      cmdBus_t r;
      r = c;
      r.rasN[base +: 2]    = {2{op[2]}};
      r.casN[base +: 2]    = {2{op[1]}};
      r.weN[base +: 2]     = {2{op[0]}};
      r.adr[16][base +: 2] = {2{op[2]}};
      r.adr[15][base +: 2] = {2{op[1]}};
      r.adr[14][base +: 2] = {2{op[0]}};
      return r;
   endfunction

   // Bank and group of the target bank
   function automatic cmdBus_t putBank(cmdBus_t c, logic [2:0] base,
                                       logic [`MC_BABITS-1:0] bank,
                                       logic [`MC_BGBITS-1:0] group);
      cmdBus_t r;
      r = c;
      for (int i = 0; i < `MC_BABITS; i++) begin
         r.ba[i][base +: 2] = {2{bank[i]}};
      end
      for (int i = 0; i < `MC_BGBITS; i++) begin
         r.bg[i][base +: 2] = {2{group[i]}};
      end
      return r;
   endfunction

   // Chip select low for one rank
   function automatic cmdBus_t putCs(cmdBus_t c, logic [2:0] base,
                                     logic [`MC_RKBITS-1:0] rank);
      cmdBus_t r;
      r = c;
      r.csN[rank][base +: 2] = 2'b00;
      return r;
   endfunction

   // ------------------------------
   // CAS qualifiers
   // ------------------------------

   // Read or write requested, maintenance yields to it
   logic       rwReq;
   logic       casSent;
   logic [2:0] casBase;
   ddrOp_t     casOp;

   assign rwReq   = casReq.read | casReq.write;
   assign casSent = rwReq & tranSentC;
   assign casBase = casSlot2 ? 3'd4 : 3'd0;
   assign casOp   = casReq.read ? RD : WR;

   always_comb begin : encode
      cmdBus_t c;

      // Start from the idle bus
      c.actN = '1;
      c.rasN = '1;
      c.casN = '1;
      c.weN  = '1;
      c.adr  = {`MC_ABITS{idleAddr}};
      c.ba   = {`MC_BABITS{idleAddr}};
      c.bg   = {`MC_BGBITS{idleAddr}};
      c.csN  = '1;

      // Read or write CAS in slots 0-1 or 4-5
      if (casSent) begin
         for (int i = 0; i < `MC_ABITS; i++) begin
            c.adr[i][casBase +: 2] = 2'b00;
         end
         for (int i = 0; i < `MC_COLBITS; i++) begin
            c.adr[i][casBase +: 2] = {2{casReq.col[i]}};
         end
         // A10 carries auto precharge
         c.adr[10][casBase +: 2] = {2{casReq.autoPre}};
         c = putOp(c, casBase, casOp);
         c = putBank(c, casBase, casReq.bank, casReq.group);
         c = putCs(c, casBase, casReq.rank);
      end

      // Maintenance in slots 6-7 only while no CAS is requested
      if (!rwReq) begin
         if (maintReq.preAll) begin
            // All address bits high, A10 selects all banks
            for (int i = 0; i < `MC_ABITS; i++) begin
               c.adr[i][preBase +: 2] = 2'b11;
            end
            c = putOp(c, preBase, PRE);
            c = putBank(c, preBase, '0, '0);
            c = putCs(c, preBase, maintReq.rank);
         end else if (maintReq.refresh) begin
            c = putOp(c, preBase, REF);
            c = putCs(c, preBase, maintReq.rank);
         end else if (maintReq.zq) begin
            // A10 low gives ZQ short
            c = putOp(c, preBase, ZQC);
            c.adr[10][preBase +: 2] = 2'b00;
            if (maintReq.zqAll) begin
               for (int i = 0; i < `MC_CSBITS; i++) begin
                  c.csN[i][preBase +: 2] = 2'b00;
               end
            end else begin
               c = putCs(c, preBase, maintReq.rank);
            end
         end
      end

      // Activate in slots 2-3, row overwrites the opcode on A16..A14
      if (actReq.valid) begin
         c.actN[actBase +: 2] = 2'b00;
         c = putOp(c, actBase, ACT);
         for (int i = 0; i < `MC_ABITS; i++) begin
            c.adr[i][actBase +: 2] = {2{actReq.row[i]}};
         end
         c = putBank(c, actBase, actReq.bank, actReq.group);
         c = putCs(c, actBase, actReq.rank);
      end

      // Per-bank precharge replaces whatever maintenance put in slots 6-7
      if (preReq.valid) begin
         for (int i = 0; i < `MC_ABITS; i++) begin
            c.adr[i][preBase +: 2] = 2'b00;
         end
         for (int i = 0; i < `MC_CSBITS; i++) begin
            c.csN[i][preBase +: 2] = 2'b11;
         end
         c = putOp(c, preBase, PRE);
         c = putBank(c, preBase, preReq.bank, preReq.group);
         c = putCs(c, preBase, preReq.rank);
      end

      cmd = c;
   end

endmodule

// ==== mcCtl.sv ====
// ------------------------------
// DDR4 command slot encoder top level
// Scheduler requests in, slotted command pins and CAS grant out, same cycle
// ------------------------------

module mcCtl #(
   // Set for clocks that need the long rank switch gap
   parameter bit longRankSwitch = 1'b0
) (
   input  logic                clk,
   input  logic                rst,

   // Scheduler requests, held until granted
   input  mcCtlPkg::casReq_t   casReq,
   input  mcCtlPkg::actReq_t   actReq,
   input  mcCtlPkg::preReq_t   preReq,
   input  mcCtlPkg::maintReq_t maintReq,
   // Periodic read window blocks read CAS
   input  logic                perCasBlock,

   // Slotted pins towards the PHY
   output mcCtlPkg::cmdBus_t   cmd,

   // CAS grant and placement back to the scheduler
   output logic                tranSentC,
   output logic                casSlot2,
   // Auto precharge of the last sent CAS
   output logic                prevCmdAP
);

   // ------------------------------
   // CAS issue decision
   // ------------------------------

   mcCasArbiter #(
      .longRankSwitch (longRankSwitch)
   ) i_casArbiter (
      .clk         (clk),
      .rst         (rst),
      .casReq      (casReq),
      .perCasBlock (perCasBlock),
      .tranSentC   (tranSentC),
      .casSlot2    (casSlot2),
      .prevCmdAP   (prevCmdAP)
   );

   // ------------------------------
   // Slot encoding
   // ------------------------------

   // Reads the grant in the same cycle
   mcCmdEncoder i_cmdEncoder (
      .casReq    (casReq),
      .actReq    (actReq),
      .preReq    (preReq),
      .maintReq  (maintReq),
      .tranSentC (tranSentC),
      .casSlot2  (casSlot2),
      .cmd       (cmd)
   );

endmodule

// ==== mcCtlPkg.sv ====
// ------------------------------
// Types shared by the CAS arbiter, the slot encoder and the top level
// Request structs come from the scheduler, cmdBus_t goes to the PHY
// ------------------------------

`include "mcCtl_macros.svh"

package mcCtlPkg;

   // DDR4 opcode, bit 2 is RAS, bit 1 is CAS, bit 0 is WE
   typedef enum logic [2:0] {
      REF = 3'b001,
      PRE = 3'b010,
      ACT = 3'b011,
      WR  = 3'b100,
      RD  = 3'b101,
      ZQC = 3'b110
   } ddrOp_t;

   // One pin over the eight slots of a fabric cycle, slot i is bit i
   typedef logic [`MC_SLOTS-1:0] slotVec_t;

   // ------------------------------
   // Scheduler requests
   // ------------------------------

   // Read or write CAS, never both at once
   typedef struct packed {
      logic                   read;
      logic                   write;
      logic                   autoPre;
      logic [`MC_RKBITS-1:0]  rank;
      logic [`MC_BGBITS-1:0]  group;
      logic [`MC_BABITS-1:0]  bank;
      logic [`MC_COLBITS-1:0] col;
   } casReq_t;

   // Row activate
   typedef struct packed {
      logic                  valid;
      logic [`MC_RKBITS-1:0] rank;
      logic [`MC_BGBITS-1:0] group;
      logic [`MC_BABITS-1:0] bank;
      logic [`MC_ABITS-1:0]  row;
   } actReq_t;

   // Per-bank precharge
   typedef struct packed {
      logic                  valid;
      logic [`MC_RKBITS-1:0] rank;
      logic [`MC_BGBITS-1:0] group;
      logic [`MC_BABITS-1:0] bank;
   } preReq_t;

   // Maintenance, first set flag wins in the order listed
   typedef struct packed {
      logic                  preAll;
      logic                  refresh;
      logic                  zq;
      logic                  zqAll;
      logic [`MC_RKBITS-1:0] rank;
   } maintReq_t;

   // ------------------------------
   // Slotted DDR4 command pins
   // ------------------------------

   // All control pins are active low
   typedef struct packed {
      slotVec_t                  actN;
      slotVec_t                  rasN;
      slotVec_t                  casN;
      slotVec_t                  weN;
      slotVec_t [`MC_ABITS-1:0]  adr;
      slotVec_t [`MC_BABITS-1:0] ba;
      slotVec_t [`MC_BGBITS-1:0] bg;
      slotVec_t [`MC_CSBITS-1:0] csN;
   } cmdBus_t;

endpackage

// ==== mcCtl_macros.svh ====
// ------------------------------
// Shared widths and idle levels of the DDR4 command slot encoder
// Included by the package and by every RTL file that sizes a port
// ------------------------------

`ifndef MC_CTL_MACROS_SVH
`define MC_CTL_MACROS_SVH

// ------------------------------
// DRAM pin counts
// ------------------------------

// A17..A0, with A16..A14 doubling as RAS/CAS/WE
`define MC_ABITS 18
`define MC_BABITS 2
`define MC_BGBITS 2

// Rank index and one chip select per rank
`define MC_RKBITS 2
`define MC_CSBITS 4

// Fixed column width, A9..A0
`define MC_COLBITS 10

// ------------------------------
// Fabric framing
// ------------------------------

// DRAM command slots carried by one fabric clock
`define MC_SLOTS 8

// Idle level of address, bank and group slots, 1 means low
`define MC_NOP_ADDR_LOW 1

`endif

// ==== mcCtl_props.sv ====
// ------------------------------
// CAS spacing and request rules, bound into the top level
// Failures raise $error and bump a counter the testbench reads
// ------------------------------

module mcCtlProps (
   input logic              clk,
   input logic              rst,
   input mcCtlPkg::casReq_t casReq,
   input logic              perCasBlock,
   input logic              tranSentC,
   input logic              casSlot2
);

   timeunit 1ns;
   timeprecision 1ps;

   // CAS actually placed on the bus
   logic casSent;
   int   failCount;

   initial failCount = 0;

   assign casSent = (casReq.read | casReq.write) & tranSentC;

   // Periodic read window holds reads back
   readBlocked: assert property (@(posedge clk) disable iff (!rst)
      !(casReq.read && perCasBlock && tranSentC))
      else begin
         $error("read CAS sent while the periodic block is active");
         failCount++;
      end

   // Scheduler presents one CAS kind at a time
   oneCasKind: assert property (@(posedge clk) disable iff (!rst)
      !(casReq.read && casReq.write))
      else begin
         $error("read and write requested in the same cycle");
         failCount++;
      end

   // Slot 2 followed by slot 0 would squeeze tCCD
   noSlotFallback: assert property (@(posedge clk) disable iff (!rst)
      casSent && casSlot2 |=> !(casSent && !casSlot2))
      else begin
         $error("slot 0 CAS issued right after a slot 2 CAS");
         failCount++;
      end

   // Write to write rank switch needs a dead cycle
   wrRankGap: assert property (@(posedge clk) disable iff (!rst)
      casSent && casReq.write |=>
         !(casSent && casReq.write && casReq.rank != $past(casReq.rank)))
      else begin
         $error("write sent right after a write to another rank");
         failCount++;
      end

endmodule

bind mcCtl mcCtlProps i_props (
   .clk         (clk),
   .rst         (rst),
   .casReq      (casReq),
   .perCasBlock (perCasBlock),
   .tranSentC   (tranSentC),
   .casSlot2    (casSlot2)
);

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tbMcCtl -f files.f -o simMcCtl
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

# Keep running after an assertion so the summary is printed
./obj_dir/simMcCtl +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "No errors" sim.log; then
   echo "simulation passed"
   exit 0
fi
echo "simulation failed"
exit 1

// ==== tbClkGen.sv ====
// ------------------------------
// Testbench clock and reset source
// 20 ns clock, reset held low for the first four rising edges
// ------------------------------

module tbClkGen (
   output logic clk,
   output logic rst
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int halfPeriod  = 10;
   localparam int resetCycles = 4;

   // Free running clock
   initial begin
      clk = 1'b0;
      forever #(halfPeriod) clk = ~clk;
   end

   // Release on a rising edge so the DUT sees four reset edges
   initial begin
      rst = 1'b0;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b1;
   end

endmodule

// ==== tbMcCtl.sv ====
// ------------------------------
// Testbench for the DDR4 command slot encoder
// Drives scheduler requests and checks grant and slots against a reference model
// ------------------------------

`include "mcCtl_macros.svh"

module tbMcCtl;

   timeunit 1ns;
   timeprecision 1ps;

   import mcCtlPkg::*;

   logic      clk;
   logic      rst;
   casReq_t   casReq;
   actReq_t   actReq;
   preReq_t   preReq;
   maintReq_t maintReq;
   logic      perCasBlock;
   cmdBus_t   cmd;
   logic      tranSentC;
   logic      casSlot2;
   logic      prevCmdAP;

   // Reference CAS history
   logic                  mPrevCas;
   logic [`MC_RKBITS-1:0] mPrevRank;
   logic                  mPrevSlot2;
   logic                  mPrevAP;

   int          errors;
   int          checks;
   int          mark;
   int          tries;
   logic        lastSent;
   logic [31:0] rng;
   logic [31:0] r;
   logic [`MC_RKBITS-1:0] rank;

   tbClkGen i_clkGen (
      .clk (clk),
      .rst (rst)
   );

   mcCtl i_dut (
      .clk         (clk),
      .rst         (rst),
      .casReq      (casReq),
      .actReq      (actReq),
      .preReq      (preReq),
      .maintReq    (maintReq),
      .perCasBlock (perCasBlock),
      .cmd         (cmd),
      .tranSentC   (tranSentC),
      .casSlot2    (casSlot2),
      .prevCmdAP   (prevCmdAP)
   );

   // ------------------------------
   // Random source and checks
   // ------------------------------

   function automatic logic [31:0] xorshift(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] nextRand();
      rng = xorshift(rng);
      return rng;
   endfunction

   task automatic checkVec(string name, logic [143:0] got, logic [143:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("mismatch %s got %0h expected %0h", name, got, exp);
         errors++;
      end
   endtask

   // ------------------------------
   // Reference model
   // ------------------------------

   // Grant rule, returns {sent, slot2}
   function automatic logic [1:0] grantRule();
      logic rw;
      logic blocked;
      rw      = casReq.read | casReq.write;
      blocked = casReq.read & perCasBlock;
      if (blocked || !rw) begin
         return {~blocked, 1'b0};
      end else if (!mPrevCas) begin
         return 2'b10;
      end else if (casReq.rank == mPrevRank) begin
         return {1'b1, mPrevSlot2};
      end else if (!mPrevSlot2) begin
         // Only a read may hop to the later pair
         return {casReq.read, casReq.read};
      end
      return 2'b00;
   endfunction

   function automatic logic [`MC_CSBITS-1:0] csOf(logic [`MC_RKBITS-1:0] rk);
      return ~(4'b0001 << rk);
   endfunction

   // One command on a slot pair
   function automatic cmdBus_t putPair(cmdBus_t b, int base, logic actN, logic [2:0] op,
                                       logic [`MC_ABITS-1:0] a, logic [1:0] bk,
                                       logic [1:0] grp, logic [`MC_CSBITS-1:0] cs);
      cmdBus_t c;
      c = b;
      for (int s = base; s < base + 2; s++) begin
         c.actN[s] = actN;
         c.rasN[s] = op[2];
         c.casN[s] = op[1];
         c.weN[s]  = op[0];
         for (int k = 0; k < `MC_ABITS; k++) begin
            c.adr[k][s] = a[k];
         end
         for (int k = 0; k < 2; k++) begin
            c.ba[k][s] = bk[k];
            c.bg[k][s] = grp[k];
         end
         for (int k = 0; k < `MC_CSBITS; k++) begin
            c.csN[k][s] = cs[k];
         end
      end
      return c;
   endfunction

   function automatic cmdBus_t expBus(logic sent, logic slot2);
      cmdBus_t    b;
      logic       rw;
      logic [2:0] op;
      // Idle pins high, address side low
      b.actN = '1;
      b.rasN = '1;
      b.casN = '1;
      b.weN  = '1;
      b.adr  = '0;
      b.ba   = '0;
      b.bg   = '0;
      b.csN  = '1;
      rw = casReq.read | casReq.write;
      op = casReq.read ? RD : WR;
      if (rw && sent) begin
         b = putPair(b, slot2 ? 4 : 0, 1'b1, op, {1'b0, op, 3'b000, casReq.autoPre, casReq.col},
                     casReq.bank, casReq.group, csOf(casReq.rank));
      end
      if (!rw && maintReq.preAll) begin
         b = putPair(b, 6, 1'b1, PRE, {1'b1, PRE, 14'h3fff}, '0, '0, csOf(maintReq.rank));
      end else if (!rw && maintReq.refresh) begin
         b = putPair(b, 6, 1'b1, REF, {1'b0, REF, 14'h0}, '0, '0, csOf(maintReq.rank));
      end else if (!rw && maintReq.zq) begin
         b = putPair(b, 6, 1'b1, ZQC, {1'b0, ZQC, 14'h0}, '0, '0,
                     maintReq.zqAll ? 4'h0 : csOf(maintReq.rank));
      end
      if (actReq.valid) begin
         b = putPair(b, 2, 1'b0, ACT, actReq.row, actReq.bank, actReq.group, csOf(actReq.rank));
      end
      if (preReq.valid) begin
         b = putPair(b, 6, 1'b1, PRE, {1'b0, PRE, 14'h0}, preReq.bank, preReq.group,
                     csOf(preReq.rank));
      end
      return b;
   endfunction

   // ------------------------------
   // Cycle driver
   // ------------------------------

   // Entered at a falling edge with inputs driven, leaves at the next one
   task automatic runCycle();
      logic [1:0] g;
      cmdBus_t    e;
      #8;
      g = grantRule();
      e = expBus(g[1], g[0]);
      checkVec("tranSentC", 144'(tranSentC), 144'(g[1]));
      checkVec("casSlot2", 144'(casSlot2), 144'(g[0]));
      checkVec("prevCmdAP", 144'(prevCmdAP), 144'(mPrevAP));
      checkVec("cmd.actN", 144'(cmd.actN), 144'(e.actN));
      checkVec("cmd.rasN", 144'(cmd.rasN), 144'(e.rasN));
      checkVec("cmd.casN", 144'(cmd.casN), 144'(e.casN));
      checkVec("cmd.weN", 144'(cmd.weN), 144'(e.weN));
      checkVec("cmd.adr", 144'(cmd.adr), 144'(e.adr));
      checkVec("cmd.ba", 144'(cmd.ba), 144'(e.ba));
      checkVec("cmd.bg", 144'(cmd.bg), 144'(e.bg));
      checkVec("cmd.csN", 144'(cmd.csN), 144'(e.csN));
      lastSent = tranSentC & (casReq.read | casReq.write);
      @(posedge clk);
      // History follows the same edge as the DUT
      if (casReq.read || casReq.write) begin
         mPrevRank = casReq.rank;
      end
      mPrevCas = (casReq.read | casReq.write) & g[1];
      if (mPrevCas) begin
         mPrevSlot2 = g[0];
         mPrevAP    = casReq.autoPre;
      end
      @(negedge clk);
   endtask

   task automatic idleInputs();
      casReq      = '0;
      actReq      = '0;
      preReq      = '0;
      maintReq    = '0;
      perCasBlock = 1'b0;
   endtask

   // Holds a CAS until granted, like the scheduler
   task automatic sendCas(logic rd, logic [`MC_RKBITS-1:0] rk, logic ap);
      logic [31:0] x;
      int          n;
      x = nextRand();
      casReq.read    = rd;
      casReq.write   = ~rd;
      casReq.autoPre = ap;
      casReq.rank    = rk;
      casReq.group   = x[1:0];
      casReq.bank    = x[3:2];
      casReq.col     = x[13:4];
      lastSent = 1'b0;
      n = 0;
      // A refused rank switch costs one dead cycle at most
      while (!lastSent && n < 4) begin
         runCycle();
         n++;
      end
      if (!lastSent) begin
         $display("CAS to rank %0d was not granted within 4 cycles", rk);
         errors++;
      end
   endtask

   task automatic endTest(int num, string name);
      $display("test %0d %s done with %0d errors", num, name, errors - mark);
      mark = errors;
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      rng        = 32'h1049;
      errors     = 0;
      checks     = 0;
      mark       = 0;
      mPrevCas   = 1'b0;
      mPrevRank  = '0;
      mPrevSlot2 = 1'b0;
      mPrevAP    = 1'b0;
      idleInputs();
      tries = 0;
      while (rst !== 1'b1 && tries < 20) begin
         @(negedge clk);
         tries++;
      end
      if (rst !== 1'b1) begin
         $display("reset was never released");
         errors++;
      end

      // Idle bus straight out of reset
      repeat (3) runCycle();
      endTest(1, "reset and idle");

      // Lone read then lone write, both in slots 0-1
      r = nextRand();
      sendCas(1'b1, r[1:0], 1'b1);
      idleInputs();
      repeat (2) runCycle();
      sendCas(1'b0, r[3:2], 1'b0);
      idleInputs();
      repeat (2) runCycle();
      endTest(2, "single CAS");

      // Continuous traffic, ranks often repeat to build slot-2 chains
      rank = '0;
      for (int i = 0; i < 40; i++) begin
         r = nextRand();
         if (r[0]) begin
            rank = r[2:1];
         end
         sendCas(r[3] | r[4], rank, r[5]);
      end
      idleInputs();
      repeat (2) runCycle();
      endTest(3, "back-to-back spacing");

      // Blocked read stays off the bus, write still goes
      perCasBlock  = 1'b1;
      casReq.read  = 1'b1;
      casReq.rank  = 2'd1;
      casReq.col   = 10'h155;
      repeat (2) runCycle();
      sendCas(1'b0, 2'd1, 1'b0);
      idleInputs();
      runCycle();
      endTest(4, "periodic block");

      // Activate and precharge in the same cycle as a write
      r = nextRand();
      actReq.valid = 1'b1;
      actReq.rank  = r[1:0];
      actReq.group = r[3:2];
      actReq.bank  = r[5:4];
      actReq.row   = r[23:6];
      r = nextRand();
      preReq.valid = 1'b1;
      preReq.rank  = r[1:0];
      preReq.group = r[3:2];
      preReq.bank  = r[5:4];
      sendCas(1'b0, r[7:6], 1'b1);
      idleInputs();
      runCycle();
      endTest(5, "activate and precharge");

      // Maintenance kinds one by one
      for (int k = 0; k < 4; k++) begin
         r = nextRand();
         maintReq      = '0;
         maintReq.rank = r[1:0];
         case (k)
            0: maintReq.preAll = 1'b1;
            1: maintReq.refresh = 1'b1;
            default: maintReq.zq = 1'b1;
         endcase
         maintReq.zqAll = (k == 3);
         runCycle();
      end
      // Pending read pushes refresh out of slots 6-7
      maintReq         = '0;
      maintReq.refresh = 1'b1;
      sendCas(1'b1, 2'd2, 1'b0);
      casReq = '0;
      // Per-bank precharge wins over ZQ
      maintReq.refresh = 1'b0;
      maintReq.zq      = 1'b1;
      preReq.valid     = 1'b1;
      preReq.rank      = 2'd3;
      preReq.bank      = 2'd2;
      runCycle();
      idleInputs();
      runCycle();
      endTest(6, "maintenance");

      errors += i_dut.i_props.failCount;
      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
